// File: compile.f
+incdir+logic
logic/flit_pkg.sv
logic/router_pkg.sv
logic/flit_fifo.sv
logic/output_arbiter.sv
logic/mesh_router.sv
logic/noc_row.sv
tests/noc_row_tb.sv

// File: tests/noc_row_tb.sv
// drives all three local ports with directed and random single-flit traffic
// outputs are sampled on the falling edge, inputs change 1 ns after the rising edge
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_row_tb
        import flit_pkg::*;
();

        localparam logic [31:0] SEED = 32'h1cee_ecf7;
        localparam int LOOP_FLITS    = `NODES;
        localparam int HOP_FLITS     = 2 * `NODES * (`NODES - 1);
        localparam int BURST_LEN     = 8;
        localparam int RANDOM_LEN    = 60;
        localparam int TOTAL_FLITS   = LOOP_FLITS + HOP_FLITS + `NODES * (BURST_LEN + RANDOM_LEN);

        logic              clk;
        logic              rst;
        flit_t             idata [`NODES];
        logic [`NODES-1:0] ivalid;
        logic [`NODES-1:0] ordy;
        flit_t             odata [`NODES];
        logic [`NODES-1:0] ovalid;

        // accepted flits not yet ejected, oldest first
        flit_t             pending [$];
        int                sent_count;
        int                delivered;
        int                stall_cycles;
        logic [31:0]       rng;

        noc_row dut (
                .clk       ( clk       ),
                .rst       ( rst       ),
                .n0_idata  ( idata[0]  ),
                .n0_ivalid ( ivalid[0] ),
                .n0_ordy   ( ordy[0]   ),
                .n0_odata  ( odata[0]  ),
                .n0_ovalid ( ovalid[0] ),
                .n1_idata  ( idata[1]  ),
                .n1_ivalid ( ivalid[1] ),
                .n1_ordy   ( ordy[1]   ),
                .n1_odata  ( odata[1]  ),
                .n1_ovalid ( ovalid[1] ),
                .n2_idata  ( idata[2]  ),
                .n2_ivalid ( ivalid[2] ),
                .n2_ordy   ( ordy[2]   ),
                .n2_odata  ( odata[2]  ),
                .n2_ovalid ( ovalid[2] )
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next(input logic [31:0] state);
                return state * 32'd1664525 + 32'd1013904223;
        endfunction

        // XY routing in one row: the flit leaves at its dest column, unchanged
        function automatic int expected_node(input flit_t f);
                return int'(f.dest);
        endfunction

        task automatic abort_run();
                $display("TESTBENCH FAILED");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic mismatch_error(input string msg);
                $display("ERR %0t: %s", $time, msg);
                abort_run();
        endtask

        task automatic fail_with_reason(input string msg);
                $display("%s", msg);
                abort_run();
        endtask

        // called at posedge + 1 ns, returns at a later posedge + 1 ns
        task automatic send_flit(input int node, input int dest, input logic [7:0] payload);
                flit_t f;
                f.dest    = pos_t'(dest);
                f.src     = pos_t'(node);
                f.payload = payload;
                while (!ordy[node]) begin
                        @(posedge clk);
                        #1;
                end
                idata[node]  = f;
                ivalid[node] = 1'b1;
                pending.push_back(f);
                sent_count++;
                @(posedge clk);
                #1;
                ivalid[node] = 1'b0;
        endtask

        task automatic contention_burst(input int node);
                logic [31:0] state;
                state = SEED ^ (32'h9e37_79b9 * (node + 1));
                for (int i = 0; i < BURST_LEN; i++) begin
                        state = lcg_next(state);
                        send_flit(node, 1, state[31:24]);
                end
        endtask

        // about half the traffic heads for n1 to load its local port
        task automatic random_traffic(input int node);
                logic [31:0] state;
                int          dest;
                state = SEED ^ (32'h7f4a_7c15 * (node + 3));
                for (int i = 0; i < RANDOM_LEN; i++) begin
                        state = lcg_next(state);
                        if (state[18:16] < 3'd4)
                                dest = 1;
                        else
                                dest = int'(state[21:20]) % `NODES;
                        send_flit(node, dest, state[31:24]);
                        if (state[10:8] == 3'd0) begin
                                repeat (2) @(posedge clk);
                                #1;
                        end
                end
        endtask

        // bounded wait for the network to empty
        task automatic drain(input int max_cycles);
                int c;
                c = 0;
                while (pending.size() != 0 && c < max_cycles) begin
                        @(posedge clk);
                        #1;
                        c++;
                end
        endtask

        // oldest pending flit of the same source and destination pair
        task automatic check_delivery(input int node, input flit_t got);
                int    idx;
                flit_t exp;
                idx = -1;
                for (int i = 0; i < pending.size(); i++) begin
                        if (idx < 0 && pending[i].src == got.src &&
                            pending[i].dest == got.dest)
                                idx = i;
                end
                assert (idx >= 0) else
                        fail_with_reason($sformatf("unexpected delivery at node %0d of flit %h",
                                                   node, got));
                if (idx >= 0) begin
                        exp = pending[idx];
                        pending.delete(idx);
                        delivered++;
                        assert (got == exp) else
                                mismatch_error($sformatf("node %0d got %h, expected %h",
                                                         node, got, exp));
                        assert (expected_node(exp) == node) else
                                mismatch_error($sformatf("flit %h ejected at node %0d, expected %0d",
                                                         got, node, expected_node(exp)));
                end
        endtask

        // compare process
        always @(negedge clk) begin
                if (!rst) begin
                        for (int n = 0; n < `NODES; n++) begin
                                if (ovalid[n])
                                        check_delivery(n, odata[n]);
                        end
                        if (ordy != '1)
                                stall_cycles++;
                end
        end

        initial begin
                repeat (TOTAL_FLITS * 50 + 500) @(posedge clk);
                fail_with_reason("timeout, traffic did not drain within the cycle limit");
        end

        initial begin
                rst          = 1'b1;
                ivalid       = '0;
                sent_count   = 0;
                delivered    = 0;
                stall_cycles = 0;
                rng          = SEED;
                for (int n = 0; n < `NODES; n++)
                        idata[n] = '0;
                repeat (10) @(posedge clk);
                #1;
                rst = 1'b0;

                // idle network after reset
                repeat (8) begin
                        @(negedge clk);
                        assert (ovalid == '0) else mismatch_error("ovalid high after reset");
                        assert (ordy == '1) else mismatch_error("ordy low after reset");
                end
                @(posedge clk);
                #1;

                for (int n = 0; n < `NODES; n++) begin
                        rng = lcg_next(rng);
                        send_flit(n, n, rng[31:24]);
                end
                drain(200);

                // every ordered pair, one and two hops
                for (int s = 0; s < `NODES; s++) begin
                        for (int d = 0; d < `NODES; d++) begin
                                if (s != d) begin
                                        repeat (2) begin
                                                rng = lcg_next(rng);
                                                send_flit(s, d, rng[31:24]);
                                        end
                                end
                        end
                end
                drain(200);

                fork
                        contention_burst(0);
                        contention_burst(1);
                        contention_burst(2);
                join
                drain(300);

                // stalls counted from here on belong to the random phase
                stall_cycles = 0;
                fork
                        random_traffic(0);
                        random_traffic(1);
                        random_traffic(2);
                join
                assert (stall_cycles > 0) else
                        fail_with_reason("ordy never fell during random traffic, no back-pressure");
                drain(1000);

                // extra idle cycles to catch late or duplicate ejections
                repeat (20) @(posedge clk);
                $display("sent %0d, delivered %0d, ordy low on %0d cycles",
                         sent_count, delivered, stall_cycles);
                if (pending.size() != 0) begin
                        fail_with_reason($sformatf("missing flits: %0d never delivered",
                                                   pending.size()));
                end else begin
                        $display("TESTBENCH PASSED");
                        $finish;
                end
        end

endmodule

// File: logic/noc_row.sv
// three routers at x = 0, 1, 2; local ejection has no back-pressure
// inject only while nk_ordy is high
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_row
        import flit_pkg::*;
(
        input  logic  clk,
        input  logic  rst,

        input  flit_t n0_idata,
        input  logic  n0_ivalid,
        output logic  n0_ordy,
        output flit_t n0_odata,
        output logic  n0_ovalid,

        input  flit_t n1_idata,
        input  logic  n1_ivalid,
        output logic  n1_ordy,
        output flit_t n1_odata,
        output logic  n1_ovalid,

        input  flit_t n2_idata,
        input  logic  n2_ivalid,
        output logic  n2_ordy,
        output flit_t n2_odata,
        output logic  n2_ovalid
);

        // eastbound, node k to node k+1
        flit_t                 east_data [`NODES-1];
        logic  [`NODES-2:0]    east_valid;
        logic  [`NODES-2:0]    east_ready;

        // westbound, node k+1 to node k
        flit_t                 west_data [`NODES-1];
        logic  [`NODES-2:0]    west_valid;
        logic  [`NODES-2:0]    west_ready;

        // west edge, link side idle
        mesh_router n0 (
                .clk         ( clk           ),
                .rst         ( rst           ),
                .my_xpos     ( pos_t'(0)     ),
                .idata       ( n0_idata      ),
                .ivalid      ( n0_ivalid     ),
                .ordy        ( n0_ordy       ),
                .odata       ( n0_odata      ),
                .ovalid      ( n0_ovalid     ),
                .east_idata  ( west_data[0]  ),
                .east_ivalid ( west_valid[0] ),
                .east_ordy   ( west_ready[0] ),
                .east_odata  ( east_data[0]  ),
                .east_ovalid ( east_valid[0] ),
                .east_iready ( east_ready[0] ),
                .west_idata  ( '0            ),
                .west_ivalid ( 1'b0          ),
                .west_ordy   (               ),
                .west_odata  (               ),
                .west_ovalid (               ),
                .west_iready ( 1'b1          )
        );

        mesh_router n1 (
                .clk         ( clk           ),
                .rst         ( rst           ),
                .my_xpos     ( pos_t'(1)     ),
                .idata       ( n1_idata      ),
                .ivalid      ( n1_ivalid     ),
                .ordy        ( n1_ordy       ),
                .odata       ( n1_odata      ),
                .ovalid      ( n1_ovalid     ),
                .east_idata  ( west_data[1]  ),
                .east_ivalid ( west_valid[1] ),
                .east_ordy   ( west_ready[1] ),
                .east_odata  ( east_data[1]  ),
                .east_ovalid ( east_valid[1] ),
                .east_iready ( east_ready[1] ),
                .west_idata  ( east_data[0]  ),
                .west_ivalid ( east_valid[0] ),
                .west_ordy   ( east_ready[0] ),
                .west_odata  ( west_data[0]  ),
                .west_ovalid ( west_valid[0] ),
                .west_iready ( west_ready[0] )
        );

        // east edge, link side idle
        mesh_router n2 (
                .clk         ( clk           ),
                .rst         ( rst           ),
                .my_xpos     ( pos_t'(2)     ),
                .idata       ( n2_idata      ),
                .ivalid      ( n2_ivalid     ),
                .ordy        ( n2_ordy       ),
                .odata       ( n2_odata      ),
                .ovalid      ( n2_ovalid     ),
                .east_idata  ( '0            ),
                .east_ivalid ( 1'b0          ),
                .east_ordy   (               ),
                .east_odata  (               ),
                .east_ovalid (               ),
                .east_iready ( 1'b1          ),
                .west_idata  ( east_data[1]  ),
                .west_ivalid ( east_valid[1] ),
                .west_ordy   ( east_ready[1] ),
                .west_odata  ( west_data[1]  ),
                .west_ovalid ( west_valid[1] ),
                .west_iready ( west_ready[1] )
        );

endmodule

// File: logic/mesh_router.sv
// one router of the row, XY routing reduced to x only
// flits with dest beyond the row leave by an end port and are lost
`timescale 1ns/1ps

module mesh_router
        import flit_pkg::*;
        import router_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  pos_t  my_xpos,

        // local injection and ejection
        input  flit_t idata,
        input  logic  ivalid,
        output logic  ordy,
        output flit_t odata,
        output logic  ovalid,

        // east neighbor
        input  flit_t east_idata,
        input  logic  east_ivalid,
        output logic  east_ordy,
        output flit_t east_odata,
        output logic  east_ovalid,
        input  logic  east_iready,

        // west neighbor
        input  flit_t west_idata,
        input  logic  west_ivalid,
        output logic  west_ordy,
        output flit_t west_odata,
        output logic  west_ovalid,
        input  logic  west_iready
);

        // input side, indexed by port_t
        flit_t                  in_data   [NUM_PORTS];
        logic [NUM_PORTS-1:0]   in_valid;
        logic [NUM_PORTS-1:0]   in_ready;
        req_mask_t              in_pop;
        logic [NUM_PORTS-1:0]   fifo_nempty;
        flit_t                  fifo_head [NUM_PORTS];
        port_t                  route     [NUM_PORTS];

        // output side, indexed by port_t
        req_mask_t              out_req   [NUM_PORTS];
        req_mask_t              out_grant [NUM_PORTS];
        flit_t                  out_data  [NUM_PORTS];
        logic [NUM_PORTS-1:0]   out_valid;
        logic [NUM_PORTS-1:0]   out_ready;

        assign in_data[port_local]  = idata;
        assign in_data[port_east]   = east_idata;
        assign in_data[port_west]   = west_idata;
        assign in_valid[port_local] = ivalid;
        assign in_valid[port_east]  = east_ivalid;
        assign in_valid[port_west]  = west_ivalid;

        assign ordy      = in_ready[port_local];
        assign east_ordy = in_ready[port_east];
        assign west_ordy = in_ready[port_west];

        // local sink never stalls
        assign out_ready[port_local] = 1'b1;
        assign out_ready[port_east]  = east_iready;
        assign out_ready[port_west]  = west_iready;

        assign odata       = out_data[port_local];
        assign ovalid      = out_valid[port_local];
        assign east_odata  = out_data[port_east];
        assign east_ovalid = out_valid[port_east];
        assign west_odata  = out_data[port_west];
        assign west_ovalid = out_valid[port_west];

        // route decision per FIFO head
        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        if (fifo_head[i].dest > my_xpos)
                                route[i] = port_east;
                        else if (fifo_head[i].dest < my_xpos)
                                route[i] = port_west;
                        else
                                route[i] = port_local;
                end
        end

        // each non-empty head requests exactly one output
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++)
                        out_req[o] = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        if (fifo_nempty[i])
                                out_req[route[i]][i] = 1'b1;
                end
        end

        // at most one arbiter grants a given input
        always_comb begin
                in_pop = '0;
                for (int o = 0; o < NUM_PORTS; o++)
                        in_pop = in_pop | out_grant[o];
        end

        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
                flit_fifo u_fifo (
                        .clk       ( clk            ),
                        .rst       ( rst            ),
                        .wr_en     ( in_valid[p]    ),
                        .wr_data   ( in_data[p]     ),
                        .rd_en     ( in_pop[p]      ),
                        .rd_data   ( fifo_head[p]   ),
                        .not_empty ( fifo_nempty[p] ),
                        .not_full  ( in_ready[p]    )
                );

                output_arbiter u_arb (
                        .clk       ( clk          ),
                        .rst       ( rst          ),
                        .req       ( out_req[p]   ),
                        .head      ( fifo_head    ),
                        .grant     ( out_grant[p] ),
                        .out_data  ( out_data[p]  ),
                        .out_valid ( out_valid[p] ),
                        .out_ready ( out_ready[p] )
                );
        end

endmodule

// File: logic/output_arbiter.sv
// one output port; grants only when the output register is free or draining
// out_ready must be tied high where the sink always accepts
`timescale 1ns/1ps

module output_arbiter
        import flit_pkg::*;
        import router_pkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  req_mask_t req,
        input  flit_t     head [NUM_PORTS],
        output req_mask_t grant,
        output flit_t     out_data,
        output logic      out_valid,
        input  logic      out_ready
);

        // highest priority input this cycle
        port_t ptr;
        port_t winner;
        port_t next_ptr;
        logic  found;
        logic  can_load;
        logic  load;

        // register empty, or its flit leaves on this edge
        assign can_load = !out_valid || out_ready;
        assign load     = found && can_load;

        // scan from ptr, wrapping through all inputs
        always_comb begin
                int idx;
                found  = 1'b0;
                winner = port_local;
                for (int off = 0; off < NUM_PORTS; off++) begin
                        idx = (int'(ptr) + off) % NUM_PORTS;
                        if (!found && req[idx]) begin
                                found  = 1'b1;
                                winner = port_t'(idx);
                        end
                end
        end

        always_comb begin
                grant = '0;
                if (load)
                        grant[winner] = 1'b1;
        end

        // winner drops to lowest priority next time
        assign next_ptr = (winner == port_west) ? port_local : port_t'(winner + 2'd1);

        always_ff @(posedge clk) begin
                if (rst) begin
                        ptr       <= port_local;
                        out_valid <= 1'b0;
                end else begin
                        if (load) begin
                                ptr       <= next_ptr;
                                out_valid <= 1'b1;
                        end else if (out_ready) begin
                                out_valid <= 1'b0;
                        end
                end
        end

        // payload only moves on a grant
        always_ff @(posedge clk) begin
                if (load)
                        out_data <= head[winner];
        end

endmodule

// File: logic/flit_fifo.sv
// writes while full are dropped, so the sender must watch not_full
// head flit is visible the cycle after its write
`timescale 1ns/1ps
`include "noc_macros.svh"

module flit_fifo
        import flit_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  logic  wr_en,
        input  flit_t wr_data,
        input  logic  rd_en,
        output flit_t rd_data,
        output logic  not_empty,
        output logic  not_full
);

        localparam int DEPTH = `FIFO_DEPTH;
        localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

        flit_t        mem [DEPTH];
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic [AW:0]   count;
        logic          do_wr;
        logic          do_rd;

        assign do_wr = wr_en && not_full;
        assign do_rd = rd_en && not_empty;

        assign not_empty = (count != '0);
        assign not_full  = (count != (AW+1)'(DEPTH));
        assign rd_data   = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_wr)
                                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        if (do_rd)
                                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        // simultaneous push and pop leaves the level unchanged
                        if (do_wr && !do_rd)
                                count <= count + 1'b1;
                        else if (do_rd && !do_wr)
                                count <= count - 1'b1;
                end
        end

        // storage, no reset needed
        always_ff @(posedge clk) begin
                if (do_wr)
                        mem[wr_ptr] <= wr_data;
        end

endmodule

// File: logic/router_pkg.sv
// router-internal port numbering; the same encoding serves inputs and outputs
package router_pkg;

        // local, east and west
        localparam int NUM_PORTS = 3;

        // also the round-robin order
        typedef enum logic [1:0] {
                port_local = 2'd0,
                port_east  = 2'd1,
                port_west  = 2'd2
        } port_t;

        // one bit per input port
        typedef logic [NUM_PORTS-1:0] req_mask_t;

endpackage

// File: logic/flit_pkg.sv
// flit format for single-flit packets, 12 bits with the default macros
`include "noc_macros.svh"

package flit_pkg;

        // router x position in the row
        typedef logic [`POS_W-1:0] pos_t;

        // routed on dest only, src rides along for the sink
        typedef struct packed {
                pos_t               dest;
                pos_t               src;
                logic [`DATA_W-1:0] payload;
        } flit_t;

endpackage

// File: logic/noc_macros.svh
// sizing for the three-router row; positions must fit in POS_W bits
// FIFO_DEPTH need not be a power of two
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// payload bits per flit
`define DATA_W 8

// x position width
`define POS_W 2

// routers in the row
`define NODES 3

// flits held per router input
`define FIFO_DEPTH 4

`endif
